// ==== common/core_settings.svh ====
// ------------------------------------------------------------
// Width and size macros shared by the load/store core
// ------------------------------------------------------------
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data word and byte address width
`define CORE_DATA_W 32

// External interrupt number width
`define CORE_IRQ_NUM_W 6

// Bytes per interrupt descriptor table entry
`define CORE_IDT_ENTRY_BYTES 4

`endif

// ==== common/core_pkg.sv ====
// ------------------------------------------------------------
// Types for the load/store path and interrupt entry
// ------------------------------------------------------------
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_DATA_W-1:0] word_t;

	// Byte address as wide as a data word
	typedef logic [`CORE_DATA_W-1:0] addr_t;

	// Access size where 3 means none
	typedef enum logic [1:0] {
		LDST_BYTE = 2'd0,
		LDST_HALF = 2'd1,
		LDST_WORD = 2'd2,
		LDST_NONE = 2'd3
	} ldst_order_t;

	// One memory access
	// rw is 1 for a write and 0 for a read
	typedef struct packed {
		logic        rw;
		ldst_order_t order;
		addr_t       addr;
		word_t       data;
	} ldst_req_t;

	typedef logic [`CORE_IRQ_NUM_W-1:0] irq_num_t;

endpackage

`default_nettype wire

// ==== ldst/execute_ldst.sv ====
// ------------------------------------------------------------
// Execute-side load/store unit with lane alignment
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module execute_ldst import core_pkg::*; (
	input  wire        iCLOCK,
	input  wire        rst_n,
	input  wire        exe_req,
	input  ldst_req_t  exe_cmd,
	output logic       exe_busy,
	output logic       exe_resp_valid,
	output word_t      exe_resp_data,
	// Shared memory path
	output logic       mem_req,
	output ldst_req_t  mem_cmd,
	input  wire        mem_busy,
	input  wire        mem_valid,
	input  word_t      mem_rdata
);

	typedef enum logic [1:0] {
		EXE_IDLE,
		EXE_REQ,
		EXE_WAIT
	} exe_state_t;

	exe_state_t state;

	// Store data moved into the lane picked by the low address bits
	function automatic word_t store_lane(input ldst_req_t cmd);
		case (cmd.order)
			LDST_BYTE: return word_t'(cmd.data[7:0]) << {cmd.addr[1:0], 3'b000};
			LDST_HALF: return word_t'(cmd.data[15:0]) << {cmd.addr[1], 4'b0000};
			default:   return cmd.data;
		endcase
	endfunction

	// Load data brought down to bit 0, zero-extended
	function automatic word_t load_align(input word_t rdata, input ldst_req_t cmd);
		word_t shifted;
		shifted = rdata >> {cmd.addr[1:0], 3'b000};
		case (cmd.order)
			LDST_BYTE: return word_t'(shifted[7:0]);
			LDST_HALF: return cmd.addr[1] ? word_t'(rdata[31:16]) : word_t'(rdata[15:0]);
			default:   return rdata;
		endcase
	endfunction

	assign exe_busy = (state != EXE_IDLE);
	assign mem_req  = (state == EXE_REQ);

	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			state          <= EXE_IDLE;
			exe_resp_valid <= 1'b0;
		end else begin
			exe_resp_valid <= 1'b0;
			case (state)
				EXE_IDLE: begin
					if (exe_req) begin
						state <= EXE_REQ;
					end
				end
				EXE_REQ: begin
					// Held until the arbiter is free
					if (!mem_busy) begin
						state <= EXE_WAIT;
					end
				end
				EXE_WAIT: begin
					if (mem_valid) begin
						exe_resp_valid <= 1'b1;
						state          <= EXE_IDLE;
					end
				end
				default: state <= EXE_IDLE;
			endcase
		end
	end

	// Captured request and load result
	always_ff @(posedge iCLOCK) begin
		if (state == EXE_IDLE && exe_req) begin
			mem_cmd.rw    <= exe_cmd.rw;
			mem_cmd.order <= exe_cmd.order;
			mem_cmd.addr  <= exe_cmd.addr;
			mem_cmd.data  <= store_lane(exe_cmd);
		end
		if (state == EXE_WAIT && mem_valid) begin
			exe_resp_data <= load_align(mem_rdata, mem_cmd);
		end
	end

endmodule

`default_nettype wire

// ==== ldst/ldst_arbiter.sv ====
// ------------------------------------------------------------
// Arbiter between execute and interrupt entry on the data path
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ldst_arbiter import core_pkg::*; (
	input  wire        iCLOCK,
	input  wire        rst_n,
	// Execute unit
	input  wire        exe_req,
	input  ldst_req_t  exe_cmd,
	output logic       exe_busy,
	output logic       exe_valid,
	output word_t      exe_rdata,
	// Interrupt entry
	input  wire        irq_req,
	input  ldst_req_t  irq_cmd,
	output logic       irq_busy,
	output logic       irq_valid,
	output word_t      irq_rdata,
	// Data port
	output logic       port_req,
	output ldst_req_t  port_cmd,
	input  wire        port_busy,
	input  wire        port_valid,
	input  word_t      port_rdata
);

	logic in_flight;
	logic owner_irq;
	logic path_free;
	logic grant_irq;
	logic grant_exe;

	assign path_free = !in_flight && !port_busy;

	// Interrupt entry wins a tie
	assign grant_irq = path_free && irq_req;
	assign grant_exe = path_free && exe_req && !irq_req;

	assign irq_busy = !path_free;
	assign exe_busy = !path_free || irq_req;

	assign port_req = grant_irq || grant_exe;
	assign port_cmd = grant_irq ? irq_cmd : exe_cmd;

	// Response only to the owner
	assign irq_valid = port_valid && in_flight && owner_irq;
	assign exe_valid = port_valid && in_flight && !owner_irq;
	assign irq_rdata = port_rdata;
	assign exe_rdata = port_rdata;

	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			in_flight <= 1'b0;
			owner_irq <= 1'b0;
		end else if (port_req) begin
			in_flight <= 1'b1;
			owner_irq <= grant_irq;
		end else if (port_valid) begin
			in_flight <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== ldst/data_port.sv ====
// ------------------------------------------------------------
// Data memory port with one outstanding transaction
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module data_port import core_pkg::*; (
	input  wire        iCLOCK,
	input  wire        rst_n,
	// Arbiter side
	input  wire        req,
	input  ldst_req_t  cmd,
	output logic       busy,
	output logic       valid,
	output word_t      rdata,
	// External memory
	output logic       data_req,
	input  wire        data_lock,
	output ldst_req_t  data_cmd,
	input  wire        data_valid,
	input  word_t      data_rdata
);

	logic outstanding;
	logic take;

	assign take = req && !outstanding;

	// Busy from acceptance until memory answers
	assign busy = outstanding;

	// Completion goes back in the same cycle
	assign valid = data_valid && outstanding;
	assign rdata = data_rdata;

	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
			data_req    <= 1'b0;
		end else begin
			if (take) begin
				outstanding <= 1'b1;
				data_req    <= 1'b1;
			end else begin
				// Memory took it once lock is low
				if (data_req && !data_lock) begin
					data_req <= 1'b0;
				end
				if (data_valid) begin
					outstanding <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (take) begin
			data_cmd <= cmd;
		end
	end

endmodule

`default_nettype wire

// ==== src/interrupt_entry.sv ====
// ------------------------------------------------------------
// Interrupt entry that reads the descriptor table and jumps
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module interrupt_entry import core_pkg::*; (
	input  wire        iCLOCK,
	input  wire        rst_n,
	input  wire        irq_valid,
	input  irq_num_t   irq_num,
	output logic       irq_ack,
	input  addr_t      idtr,
	output logic       jump_valid,
	output addr_t      jump_addr,
	// Shared memory path
	output logic       mem_req,
	output ldst_req_t  mem_cmd,
	input  wire        mem_busy,
	input  wire        mem_valid,
	input  word_t      mem_rdata
);

	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_READ,
		IRQ_WAIT
	} irq_state_t;

	irq_state_t state;
	irq_num_t   irq_num_q;

	// Table entry address from the latched number
	assign mem_cmd.rw    = 1'b0;
	assign mem_cmd.order = LDST_WORD;
	assign mem_cmd.addr  = idtr + addr_t'(irq_num_q) * addr_t'(`CORE_IDT_ENTRY_BYTES);
	assign mem_cmd.data  = '0;

	assign mem_req = (state == IRQ_READ);

	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			state      <= IRQ_IDLE;
			irq_ack    <= 1'b0;
			jump_valid <= 1'b0;
		end else begin
			irq_ack    <= 1'b0;
			jump_valid <= 1'b0;
			case (state)
				IRQ_IDLE: begin
					if (irq_valid) begin
						irq_ack <= 1'b1;
						state   <= IRQ_READ;
					end
				end
				IRQ_READ: begin
					// Arbiter takes the read once busy drops
					if (!mem_busy) begin
						state <= IRQ_WAIT;
					end
				end
				IRQ_WAIT: begin
					if (mem_valid) begin
						jump_valid <= 1'b1;
						state      <= IRQ_IDLE;
					end
				end
				default: state <= IRQ_IDLE;
			endcase
		end
	end

	// Number and handler address
	always_ff @(posedge iCLOCK) begin
		if (state == IRQ_IDLE && irq_valid) begin
			irq_num_q <= irq_num;
		end
		if (state == IRQ_WAIT && mem_valid) begin
			jump_addr <= addr_t'(mem_rdata);
		end
	end

endmodule

`default_nettype wire

// ==== src/core_ldst_top.sv ====
// ------------------------------------------------------------
// Load/store core top with execute unit, interrupt entry,
// arbiter and data memory port
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module core_ldst_top import core_pkg::*; (
	input  wire        iCLOCK,
	input  wire        rst_n,
	// Execute side
	input  wire        exe_req,
	input  ldst_req_t  exe_cmd,
	output logic       exe_busy,
	output logic       exe_resp_valid,
	output word_t      exe_resp_data,
	// Interrupt
	input  wire        irq_valid,
	input  irq_num_t   irq_num,
	output logic       irq_ack,
	input  addr_t      idtr,
	output logic       jump_valid,
	output addr_t      jump_addr,
	// Data memory
	output logic       data_req,
	input  wire        data_lock,
	output ldst_req_t  data_cmd,
	input  wire        data_valid,
	input  word_t      data_rdata
);

	// Execute unit to arbiter
	logic      exe2arb_req;
	ldst_req_t exe2arb_cmd;
	logic      arb2exe_busy;
	logic      arb2exe_valid;
	word_t     arb2exe_rdata;

	// Interrupt entry to arbiter
	logic      irq2arb_req;
	ldst_req_t irq2arb_cmd;
	logic      arb2irq_busy;
	logic      arb2irq_valid;
	word_t     arb2irq_rdata;

	// Arbiter to data port
	logic      arb2port_req;
	ldst_req_t arb2port_cmd;
	logic      port2arb_busy;
	logic      port2arb_valid;
	word_t     port2arb_rdata;

	execute_ldst execute_unit (
		.iCLOCK(iCLOCK),
		.rst_n(rst_n),
		.exe_req(exe_req),
		.exe_cmd(exe_cmd),
		.exe_busy(exe_busy),
		.exe_resp_valid(exe_resp_valid),
		.exe_resp_data(exe_resp_data),
		.mem_req(exe2arb_req),
		.mem_cmd(exe2arb_cmd),
		.mem_busy(arb2exe_busy),
		.mem_valid(arb2exe_valid),
		.mem_rdata(arb2exe_rdata)
	);

	interrupt_entry irq_entry (
		.iCLOCK(iCLOCK),
		.rst_n(rst_n),
		.irq_valid(irq_valid),
		.irq_num(irq_num),
		.irq_ack(irq_ack),
		.idtr(idtr),
		.jump_valid(jump_valid),
		.jump_addr(jump_addr),
		.mem_req(irq2arb_req),
		.mem_cmd(irq2arb_cmd),
		.mem_busy(arb2irq_busy),
		.mem_valid(arb2irq_valid),
		.mem_rdata(arb2irq_rdata)
	);

	ldst_arbiter ldst_arb (
		.iCLOCK(iCLOCK),
		.rst_n(rst_n),
		.exe_req(exe2arb_req),
		.exe_cmd(exe2arb_cmd),
		.exe_busy(arb2exe_busy),
		.exe_valid(arb2exe_valid),
		.exe_rdata(arb2exe_rdata),
		.irq_req(irq2arb_req),
		.irq_cmd(irq2arb_cmd),
		.irq_busy(arb2irq_busy),
		.irq_valid(arb2irq_valid),
		.irq_rdata(arb2irq_rdata),
		.port_req(arb2port_req),
		.port_cmd(arb2port_cmd),
		.port_busy(port2arb_busy),
		.port_valid(port2arb_valid),
		.port_rdata(port2arb_rdata)
	);

	data_port dport (
		.iCLOCK(iCLOCK),
		.rst_n(rst_n),
		.req(arb2port_req),
		.cmd(arb2port_cmd),
		.busy(port2arb_busy),
		.valid(port2arb_valid),
		.rdata(port2arb_rdata),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_cmd(data_cmd),
		.data_valid(data_valid),
		.data_rdata(data_rdata)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_core_ldst.sv ====
// ------------------------------------------------------------
// Testbench for the load/store core with memory model,
// vector replay, compare tasks and watchdog
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_core_ldst import core_pkg::*; ();

	localparam int    VEC_COLS        = 6;
	localparam int    VEC_LINES       = 48;
	localparam int    CYCLES_PER_LINE = 40;
	localparam addr_t IDT_BASE        = 32'h0000_0200;

	logic      iCLOCK = 1'b0;
	logic      rst_n = 1'b0;
	logic      exe_req = 1'b0;
	ldst_req_t exe_cmd = '0;
	logic      exe_busy;
	logic      exe_resp_valid;
	word_t     exe_resp_data;
	logic      irq_valid = 1'b0;
	irq_num_t  irq_num = '0;
	logic      irq_ack;
	addr_t     idtr = IDT_BASE;
	logic      jump_valid;
	addr_t     jump_addr;
	logic      data_req;
	logic      data_lock = 1'b0;
	ldst_req_t data_cmd;
	logic      data_valid = 1'b0;
	word_t     data_rdata = '0;

	word_t       mem [0:255];
	logic [31:0] vec [0:VEC_COLS*VEC_LINES-1];
	logic [31:0] lfsr_state = 32'h8a8e_7925;
	logic        pending = 1'b0;
	logic [1:0]  countdown = 2'd0;
	ldst_req_t   pend_cmd = '0;
	int          budget_cycles = 0;
	string       waiting_for = "start of the run";

	core_ldst_top DUT (
		.iCLOCK(iCLOCK),
		.rst_n(rst_n),
		.exe_req(exe_req),
		.exe_cmd(exe_cmd),
		.exe_busy(exe_busy),
		.exe_resp_valid(exe_resp_valid),
		.exe_resp_data(exe_resp_data),
		.irq_valid(irq_valid),
		.irq_num(irq_num),
		.irq_ack(irq_ack),
		.idtr(idtr),
		.jump_valid(jump_valid),
		.jump_addr(jump_addr),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_cmd(data_cmd),
		.data_valid(data_valid),
		.data_rdata(data_rdata)
	);

	always #4 iCLOCK = ~iCLOCK;

	// Galois LFSR stepped once per bit taken
	function automatic logic rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		return b;
	endfunction

	// Byte enables from order and low address bits
	function automatic word_t merge_store(input word_t old, input ldst_req_t cmd);
		logic [3:0] be;
		word_t      res;
		case (cmd.order)
			LDST_BYTE: be = 4'b0001 << cmd.addr[1:0];
			LDST_HALF: be = cmd.addr[1] ? 4'b1100 : 4'b0011;
			default:   be = 4'b1111;
		endcase
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				res[i*8 +: 8] = cmd.data[i*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_load(input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("ERR %0t ns exe_resp_data got %h expected %h", $time, got, expected);
			abort_run();
		end
	endtask

	task automatic check_jump(input addr_t got, input addr_t expected);
		if (got !== expected) begin
			$display("ERR %0t ns jump_addr got %h expected %h", $time, got, expected);
			abort_run();
		end
	endtask

	task automatic control_low(input string name, input logic got);
		if (got !== 1'b0) begin
			$display("ERR %0t ns %s got %b expected 0", $time, name, got);
			abort_run();
		end
	endtask

	task automatic issue_exe(input logic rw, input ldst_order_t order, input addr_t addr,
			input word_t data);
		ldst_req_t cmd;
		cmd.rw    = rw;
		cmd.order = order;
		cmd.addr  = addr;
		cmd.data  = data;
		@(posedge iCLOCK);
		exe_req <= 1'b1;
		exe_cmd <= cmd;
		@(posedge iCLOCK);
		exe_req <= 1'b0;
	endtask

	// Busy must hold until the response strobe
	task automatic wait_exe_result(input logic is_load, input word_t expected);
		waiting_for = "exe_resp_valid";
		@(negedge iCLOCK);
		while (!exe_resp_valid) begin
			if (!exe_busy) begin
				$display("exe_busy dropped at %0t ns before exe_resp_valid", $time);
				abort_run();
			end else begin
				@(negedge iCLOCK);
			end
		end
		if (is_load) begin
			check_load(exe_resp_data, expected);
		end
	endtask

	task automatic raise_irq(input irq_num_t num);
		irq_valid <= 1'b1;
		irq_num   <= num;
	endtask

	task automatic wait_jump(input addr_t expected);
		waiting_for = "irq_ack";
		@(negedge iCLOCK);
		while (!irq_ack) begin
			@(negedge iCLOCK);
		end
		@(posedge iCLOCK);
		irq_valid <= 1'b0;
		waiting_for = "jump_valid";
		@(negedge iCLOCK);
		while (!jump_valid) begin
			if (irq_ack) begin
				$display("A second irq_ack came at %0t ns for one interrupt", $time);
				abort_run();
			end else begin
				@(negedge iCLOCK);
			end
		end
		check_jump(jump_addr, expected);
		// The jump is a single-cycle pulse
		@(negedge iCLOCK);
		if (jump_valid) begin
			$display("jump_valid stayed high at %0t ns for one interrupt", $time);
			abort_run();
		end
	endtask

	// Memory model with random lock and 1 to 3 cycles of latency
	always @(posedge iCLOCK) begin : memory_model
		logic [1:0] delay_bits;
		data_lock  <= rand_bit();
		data_valid <= 1'b0;
		if (pending) begin
			if (countdown == 2'd0) begin
				pending    <= 1'b0;
				data_valid <= 1'b1;
				data_rdata <= mem[pend_cmd.addr[9:2]];
				if (pend_cmd.rw) begin
					mem[pend_cmd.addr[9:2]] <= merge_store(mem[pend_cmd.addr[9:2]], pend_cmd);
				end
			end else begin
				countdown <= countdown - 2'd1;
			end
		end else if (data_req && !data_lock) begin
			delay_bits[1] = rand_bit();
			delay_bits[0] = rand_bit();
			pending   <= 1'b1;
			pend_cmd  <= data_cmd;
			countdown <= (delay_bits == 2'd3) ? 2'd0 : delay_bits;
		end
	end

	initial begin : watchdog
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge iCLOCK);
		$display("Timeout after %0d cycles, %s never came", budget_cycles, waiting_for);
		abort_run();
	end

	initial begin : replay
		int          line;
		int          base;
		int          line_count;
		logic [31:0] kind;
		ldst_order_t order;
		addr_t       addr;
		word_t       data;
		word_t       expected;
		irq_num_t    num;

		$readmemh("testbench/ldst_vectors.txt", vec);
		line_count = 0;
		while (line_count < VEC_LINES && vec[line_count*VEC_COLS] !== 32'h0) begin
			line_count++;
		end
		budget_cycles = (line_count + 1) * CYCLES_PER_LINE;

		// Fill pattern first and file words on top of it
		for (int i = 0; i < 256; i++) begin
			mem[i] <= {8'hc3, i[7:0], ~i[7:0], i[7:0]};
		end
		for (line = 0; line < line_count; line++) begin
			base = line * VEC_COLS;
			if (vec[base] == 32'h1) begin
				mem[vec[base+2][9:2]] <= vec[base+3];
			end
		end

		repeat (2) @(posedge iCLOCK);
		rst_n <= 1'b1;
		@(negedge iCLOCK);
		control_low("exe_busy", exe_busy);
		control_low("exe_resp_valid", exe_resp_valid);
		control_low("irq_ack", irq_ack);
		control_low("jump_valid", jump_valid);
		control_low("data_req", data_req);

		for (line = 0; line < line_count; line++) begin
			base     = line * VEC_COLS;
			kind     = vec[base];
			order    = ldst_order_t'(vec[base+1][1:0]);
			addr     = vec[base+2];
			data     = vec[base+3];
			expected = vec[base+4];
			num      = irq_num_t'(vec[base+5]);
			case (kind)
				32'h1: begin
					// Already in memory
				end
				32'h2: begin
					issue_exe(1'b0, order, addr, '0);
					wait_exe_result(1'b1, expected);
				end
				32'h3: begin
					issue_exe(1'b1, order, addr, data);
					wait_exe_result(1'b0, '0);
				end
				32'h4: begin
					@(posedge iCLOCK);
					raise_irq(num);
					wait_jump(expected);
				end
				32'h5: begin
					// Interrupt raised while the load is still pending
					issue_exe(1'b0, order, addr, '0);
					raise_irq(num);
					fork
						wait_exe_result(1'b1, expected);
						wait_jump(data);
					join
				end
				default: begin
					$display("Vector line %0d has an unknown kind %h", line, kind);
					abort_run();
				end
			endcase
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/ldst_vectors.txt ====
// Columns: kind order addr data expect irq, all hex
// Kinds: 1 memory word, 2 load, 3 store, 4 interrupt, 5 load with interrupt, 0 end
// Kind 4 expects the jump address, kind 5 expects the load result and the jump in data
1 0 00000000 11223344 00000000 00
1 0 00000004 a5b6c7d8 00000000 00
1 0 00000008 00000000 00000000 00
1 0 0000000c deadbeef 00000000 00
1 0 00000010 0f0f0f0f 00000000 00
1 0 00000200 00000800 00000000 00
1 0 0000020c 00001000 00000000 00
1 0 00000228 00002040 00000000 00
1 0 000002fc 0000fffc 00000000 00
2 2 00000000 00000000 11223344 00
2 0 00000000 00000000 00000044 00
2 0 00000001 00000000 00000033 00
2 0 00000002 00000000 00000022 00
2 0 00000003 00000000 00000011 00
2 1 00000004 00000000 0000c7d8 00
2 1 00000006 00000000 0000a5b6 00
2 2 00000004 00000000 a5b6c7d8 00
3 0 00000009 000000ab 00000000 00
3 1 0000000a 00001234 00000000 00
3 0 00000008 00000077 00000000 00
2 2 00000008 00000000 1234ab77 00
3 2 00000010 cafef00d 00000000 00
2 2 00000010 00000000 cafef00d 00
3 1 00000012 ffff5a5a 00000000 00
2 1 00000012 00000000 00005a5a 00
2 2 00000010 00000000 5a5af00d 00
3 0 0000000e 12345699 00000000 00
2 2 0000000c 00000000 de99beef 00
2 0 0000000f 00000000 000000de 00
4 0 00000000 00000000 00001000 03
4 0 00000000 00000000 0000fffc 3f
4 0 00000000 00000000 00000800 00
5 2 00000004 00002040 a5b6c7d8 0a
5 0 0000000d 00001000 000000be 03
0 0 00000000 00000000 00000000 00

// ==== filelist.f ====
+incdir+common
common/core_pkg.sv
ldst/execute_ldst.sv
ldst/ldst_arbiter.sv
ldst/data_port.sv
src/interrupt_entry.sv
src/core_ldst_top.sv
testbench/tb_core_ldst.sv
